// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_axi_tmr
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= *** TEST PASSED ***

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard hw/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
+incdir+hw
hw/tmr_pkg.sv
hw/axi_lite_slave.sv
hw/lb_regs.sv
hw/tmr_ctrl.sv
hw/tmr_counter.sv
hw/axi_tmr_top.sv
dv/tb_clk_gen.sv
dv/tb_axi_tmr.sv

// File: dv/tb_axi_tmr.sv
`timescale 1ns/1ps
`default_nettype none

`include "tmr_macros.svh"

module tb_axi_tmr;

	// Cycle budget of the directed tests
	// Limit sits at four times the budget
	localparam int TEST_CYCLES    = 1250;
	localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;
	localparam int POLL_LIMIT     = 100;

	// Register map as full byte addresses
	localparam logic [31:0] A_CTRL     = 32'(`REG_CTRL);
	localparam logic [31:0] A_LOAD     = 32'(`REG_LOAD);
	localparam logic [31:0] A_COUNT    = 32'(`REG_COUNT);
	localparam logic [31:0] A_STATUS   = 32'(`REG_STATUS);
	localparam logic [31:0] A_SCRATCH0 = 32'(`REG_SCRATCH0);
	localparam logic [31:0] A_SCRATCH1 = 32'(`REG_SCRATCH1);
	localparam logic [31:0] A_HOLE0    = 32'h0000_0018;
	localparam logic [31:0] A_HOLE1    = 32'h0000_001C;

	// CTRL and STATUS field values
	localparam logic [31:0] CTRL_EN       = 32'h0000_0001;
	localparam logic [31:0] CTRL_PERIODIC = 32'h0000_0002;
	localparam logic [31:0] CTRL_IE       = 32'h0000_0004;
	localparam logic [31:0] STAT_EXPIRED  = 32'h0000_0001;
	localparam logic [31:0] STAT_RUNNING  = 32'h0000_0002;
	localparam logic [31:0] RESP_OKAY     = 32'h0000_0000;

	wire         clk;
	wire         rst_n;

	// Master side of the AXI4-Lite bus
	logic [31:0] s_axi_awaddr;
	logic        s_axi_awvalid;
	logic [2:0]  s_axi_awprot;
	wire         s_axi_awready;
	logic [31:0] s_axi_wdata;
	logic [3:0]  s_axi_wstrb;
	logic        s_axi_wvalid;
	wire         s_axi_wready;
	wire  [1:0]  s_axi_bresp;
	wire         s_axi_bvalid;
	logic        s_axi_bready;
	logic [31:0] s_axi_araddr;
	logic        s_axi_arvalid;
	logic [2:0]  s_axi_arprot;
	wire         s_axi_arready;
	wire  [31:0] s_axi_rdata;
	wire  [1:0]  s_axi_rresp;
	wire         s_axi_rvalid;
	logic        s_axi_rready;
	wire         irq;

	int          errors;
	int          checks;
	int          cycle_count = 0;

	tb_clk_gen #(
		.PERIOD_NS    (20),
		.RESET_CYCLES (3)
	) i_tb_clk_gen (
		.o_clk   (clk),
		.o_rst_n (rst_n)
	);

	axi_tmr_top i_axi_tmr_top (
		.S_AXI_ACLK      (clk),
		.S_AXI_ARESETN   (rst_n),
		.i_s_axi_awaddr  (s_axi_awaddr),
		.i_s_axi_awvalid (s_axi_awvalid),
		.i_s_axi_awprot  (s_axi_awprot),
		.o_s_axi_awready (s_axi_awready),
		.i_s_axi_wdata   (s_axi_wdata),
		.i_s_axi_wstrb   (s_axi_wstrb),
		.i_s_axi_wvalid  (s_axi_wvalid),
		.o_s_axi_wready  (s_axi_wready),
		.o_s_axi_bresp   (s_axi_bresp),
		.o_s_axi_bvalid  (s_axi_bvalid),
		.i_s_axi_bready  (s_axi_bready),
		.i_s_axi_araddr  (s_axi_araddr),
		.i_s_axi_arvalid (s_axi_arvalid),
		.i_s_axi_arprot  (s_axi_arprot),
		.o_s_axi_arready (s_axi_arready),
		.o_s_axi_rdata   (s_axi_rdata),
		.o_s_axi_rresp   (s_axi_rresp),
		.o_s_axi_rvalid  (s_axi_rvalid),
		.i_s_axi_rready  (s_axi_rready),
		.o_irq           (irq)
	);

	//////////////////////////////
	// Bus tasks
	//////////////////////////////

	task automatic compare_value(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAIL @ %0t: %s got 0x%08h expected 0x%08h",
				$time, what, actual, expected);
		end
	endtask

	// Entered and left on a falling edge
	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
		s_axi_awaddr  = addr;
		s_axi_wdata   = data;
		s_axi_awvalid = 1'b1;
		s_axi_wvalid  = 1'b1;
		@(negedge clk);
		// Both readies pulse together
		while (!(s_axi_awready && s_axi_wready)) @(negedge clk);
		@(negedge clk);
		s_axi_awvalid = 1'b0;
		s_axi_wvalid  = 1'b0;
		s_axi_bready  = 1'b1;
		while (!s_axi_bvalid) @(negedge clk);
		compare_value("BRESP", 32'(s_axi_bresp), RESP_OKAY);
		@(negedge clk);
		s_axi_bready = 1'b0;
	endtask

	// RREADY stays low for hold cycles once RVALID is seen
	task automatic axi_read(input logic [31:0] addr, input int hold, output logic [31:0] data);
		s_axi_araddr  = addr;
		s_axi_arvalid = 1'b1;
		@(negedge clk);
		while (!s_axi_arready) @(negedge clk);
		@(negedge clk);
		s_axi_arvalid = 1'b0;
		while (!s_axi_rvalid) @(negedge clk);
		data = s_axi_rdata;
		compare_value("RRESP", 32'(s_axi_rresp), RESP_OKAY);
		// Stalled response must stay put
		for (int i = 0; i < hold; i++) begin
			@(negedge clk);
			compare_value("RVALID under back-pressure", 32'(s_axi_rvalid), 32'd1);
			compare_value("RDATA under back-pressure", s_axi_rdata, data);
		end
		s_axi_rready = 1'b1;
		@(negedge clk);
		s_axi_rready = 1'b0;
	endtask

	// Reads STATUS until expired
	// A zero count_max skips the COUNT bound
	task automatic poll_expired(input logic [31:0] count_max, input bit irq_low,
			output logic [31:0] status);
		logic [31:0] count;
		int          reads;
		status = '0;
		reads  = 0;
		while (!status[0] && reads < POLL_LIMIT) begin
			axi_read(A_STATUS, 0, status);
			if (count_max != 0) begin
				axi_read(A_COUNT, 0, count);
				compare_value("COUNT within load value", 32'(count <= count_max), 32'd1);
			end
			if (irq_low) begin
				compare_value("o_irq while masked", 32'(irq), 32'd0);
			end
			reads++;
		end
		if (!status[0]) begin
			errors++;
			$display("Expired flag was not set within %0d status reads", POLL_LIMIT);
		end
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic check_reset_values();
		logic [31:0] rd;
		// Handshake outputs idle out of reset
		compare_value("AWREADY after reset", 32'(s_axi_awready), 32'd0);
		compare_value("WREADY after reset", 32'(s_axi_wready), 32'd0);
		compare_value("BVALID after reset", 32'(s_axi_bvalid), 32'd0);
		compare_value("ARREADY after reset", 32'(s_axi_arready), 32'd0);
		compare_value("RVALID after reset", 32'(s_axi_rvalid), 32'd0);
		compare_value("o_irq after reset", 32'(irq), 32'd0);
		axi_read(A_CTRL, 0, rd);
		compare_value("CTRL after reset", rd, 32'd0);
		axi_read(A_LOAD, 0, rd);
		compare_value("LOAD after reset", rd, 32'd0);
		axi_read(A_COUNT, 0, rd);
		compare_value("COUNT after reset", rd, 32'd0);
		axi_read(A_STATUS, 0, rd);
		compare_value("STATUS after reset", rd, 32'd0);
	endtask

	task automatic scratch_readback();
		logic [31:0] d0;
		logic [31:0] d1;
		logic [31:0] rd;
		d0 = $urandom;
		d1 = $urandom;
		axi_write(A_SCRATCH0, d0);
		axi_write(A_SCRATCH1, d1);
		axi_read(A_SCRATCH0, 0, rd);
		compare_value("SCRATCH0 readback", rd, d0);
		axi_read(A_SCRATCH1, 0, rd);
		compare_value("SCRATCH1 readback", rd, d1);
		// Holes in the map read as zero
		axi_read(A_HOLE0, 0, rd);
		compare_value("unmapped 0x18", rd, 32'd0);
		axi_read(A_HOLE1, 0, rd);
		compare_value("unmapped 0x1C", rd, 32'd0);
	endtask

	task automatic oneshot_expiry();
		logic [31:0] rd;
		logic [31:0] status;
		axi_write(A_LOAD, 32'd20);
		axi_read(A_LOAD, 0, rd);
		compare_value("LOAD readback", rd, 32'd20);
		axi_write(A_CTRL, CTRL_EN | CTRL_IE);
		axi_read(A_CTRL, 0, rd);
		compare_value("CTRL readback", rd, CTRL_EN | CTRL_IE);
		poll_expired(32'd0, 1'b0, status);
		// Parked after expiry so running is clear
		compare_value("STATUS after one-shot expiry", status, STAT_EXPIRED);
		compare_value("o_irq after one-shot expiry", 32'(irq), 32'd1);
		axi_read(A_COUNT, 0, rd);
		compare_value("COUNT after one-shot expiry", rd, 32'd0);
		// Write one to clear
		axi_write(A_STATUS, STAT_EXPIRED);
		axi_read(A_STATUS, 0, rd);
		compare_value("STATUS after clear", rd, 32'd0);
		compare_value("o_irq after clear", 32'(irq), 32'd0);
		axi_write(A_CTRL, 32'd0);
	endtask

	task automatic periodic_reload();
		logic [31:0] rd;
		logic [31:0] status;
		axi_write(A_LOAD, 32'd30);
		axi_write(A_CTRL, CTRL_EN | CTRL_PERIODIC);
		axi_read(A_STATUS, 0, rd);
		compare_value("running in periodic mode", rd & STAT_RUNNING, STAT_RUNNING);
		poll_expired(32'd30, 1'b0, status);
		axi_write(A_STATUS, STAT_EXPIRED);
		// Second expiry only comes from a reload
		poll_expired(32'd30, 1'b0, status);
		compare_value("running after reload", status & STAT_RUNNING, STAT_RUNNING);
		axi_write(A_CTRL, 32'd0);
		axi_read(A_STATUS, 0, rd);
		compare_value("running after disable", rd & STAT_RUNNING, 32'd0);
		axi_write(A_STATUS, STAT_EXPIRED);
	endtask

	task automatic irq_masking();
		logic [31:0] rd;
		logic [31:0] status;
		axi_write(A_LOAD, 32'd10);
		axi_write(A_CTRL, CTRL_EN | CTRL_PERIODIC);
		poll_expired(32'd0, 1'b1, status);
		compare_value("STATUS with interrupt masked", status, STAT_EXPIRED | STAT_RUNNING);
		compare_value("o_irq with interrupt masked", 32'(irq), 32'd0);
		axi_write(A_CTRL, 32'd0);
		// Expired stays sticky while running drops
		axi_read(A_STATUS, 0, rd);
		compare_value("STATUS after disable", rd, STAT_EXPIRED);
		axi_write(A_STATUS, STAT_EXPIRED);
		axi_read(A_STATUS, 0, rd);
		compare_value("STATUS after final clear", rd, 32'd0);
	endtask

	task automatic read_backpressure();
		logic [31:0] d0;
		logic [31:0] d1;
		logic [31:0] rd;
		d0 = $urandom;
		d1 = $urandom;
		axi_write(A_SCRATCH0, d0);
		axi_write(A_SCRATCH1, d1);
		axi_read(A_SCRATCH0, 6, rd);
		compare_value("SCRATCH0 after stalled read", rd, d0);
		// Next read returns its own register
		axi_read(A_SCRATCH1, 0, rd);
		compare_value("SCRATCH1 after stalled read", rd, d1);
	endtask

	//////////////////////////////
	// Run control
	//////////////////////////////

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	initial begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		errors        = 0;
		checks        = 0;
		void'($urandom(81));
		s_axi_awaddr  = '0;
		s_axi_awvalid = 1'b0;
		s_axi_awprot  = '0;
		s_axi_wdata   = '0;
		s_axi_wstrb   = 4'hF;
		s_axi_wvalid  = 1'b0;
		s_axi_bready  = 1'b0;
		s_axi_araddr  = '0;
		s_axi_arvalid = 1'b0;
		s_axi_arprot  = '0;
		s_axi_rready  = 1'b0;
		wait (rst_n === 1'b1);
		@(negedge clk);
		check_reset_values();
		scratch_readback();
		oneshot_expiry();
		periodic_reload();
		irq_masking();
		read_backpressure();
		$display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycle_count);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 3
) (
	output logic o_clk,
	output logic o_rst_n
);

	// Free running clock, low at time zero
	initial begin
		o_clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2) o_clk = ~o_clk;
		end
	end

	// Reset held low for a fixed number of rising edges
	initial begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		// Release away from the sampling edge
		@(negedge o_clk);
		o_rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: hw/axi_lite_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "tmr_macros.svh"

module axi_lite_slave
	import tmr_pkg::*;
(
	input  wire                      S_AXI_ACLK,
	input  wire                      S_AXI_ARESETN,
	// Write address channel
	input  wire [`AXI_ADDR_W-1:0]    i_s_axi_awaddr,
	input  wire                      i_s_axi_awvalid,
	input  wire [2:0]                i_s_axi_awprot,
	output wire                      o_s_axi_awready,
	// Write data channel
	input  wire [`AXI_DATA_W-1:0]    i_s_axi_wdata,
	input  wire [`AXI_DATA_W/8-1:0]  i_s_axi_wstrb,
	input  wire                      i_s_axi_wvalid,
	output wire                      o_s_axi_wready,
	// Write response channel
	output wire [1:0]                o_s_axi_bresp,
	output wire                      o_s_axi_bvalid,
	input  wire                      i_s_axi_bready,
	// Read address channel
	input  wire [`AXI_ADDR_W-1:0]    i_s_axi_araddr,
	input  wire                      i_s_axi_arvalid,
	input  wire [2:0]                i_s_axi_arprot,
	output wire                      o_s_axi_arready,
	// Read data channel
	output wire [`AXI_DATA_W-1:0]    o_s_axi_rdata,
	output wire [1:0]                o_s_axi_rresp,
	output wire                      o_s_axi_rvalid,
	input  wire                      i_s_axi_rready,
	// Local write bus
	output wire                      o_rx_dval,
	output wire [`AXI_ADDR_W-1:0]    o_rx_addr,
	output wire [`AXI_DATA_W-1:0]    o_rx_data,
	// Local read bus
	output wire                      o_tx_req,
	output wire [`AXI_ADDR_W-1:0]    o_tx_addr,
	input  wire [`AXI_DATA_W-1:0]    i_tx_data,
	input  wire                      i_tx_dval
);

	logic                   axi_awready;
	logic                   axi_wready;
	logic                   axi_bvalid;
	logic                   axi_arready;
	logic [`AXI_ADDR_W-1:0] wr_addr;
	logic [`AXI_DATA_W-1:0] wr_data;
	logic [`AXI_ADDR_W-1:0] rd_addr;
	logic [`AXI_DATA_W-1:0] rd_data;
	rd_state_t              rd_state;
	logic                   wr_accept;
	logic                   wr_hs;
	logic                   ar_accept;
	logic                   ar_hs;

	//////////////////////////////
	// Write path
	//////////////////////////////

	// Both channels valid, nothing in flight, no response pending
	assign wr_accept = !axi_awready && !axi_bvalid && i_s_axi_awvalid && i_s_axi_wvalid;

	// AW and W complete together
	assign wr_hs = axi_awready && axi_wready && i_s_axi_awvalid && i_s_axi_wvalid;

	// Single cycle ready pulse on both channels
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			axi_awready <= 1'b0;
			axi_wready  <= 1'b0;
		end else begin
			axi_awready <= wr_accept;
			axi_wready  <= wr_accept;
		end
	end

	// Capture address and data at acceptance
	always_ff @(posedge S_AXI_ACLK) begin
		if (wr_accept) begin
			wr_addr <= i_s_axi_awaddr;
			wr_data <= i_s_axi_wdata;
		end
	end

	// Response held until the master takes it
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			axi_bvalid <= 1'b0;
		end else if (wr_hs) begin
			axi_bvalid <= 1'b1;
		end else if (i_s_axi_bready) begin
			axi_bvalid <= 1'b0;
		end
	end

	//////////////////////////////
	// Read path
	//////////////////////////////

	// New address only taken while idle
	assign ar_accept = (rd_state == RD_IDLE) && !axi_arready && i_s_axi_arvalid;
	assign ar_hs     = axi_arready && i_s_axi_arvalid;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			axi_arready <= 1'b0;
			rd_state    <= RD_IDLE;
		end else begin
			axi_arready <= ar_accept;
			case (rd_state)
				RD_IDLE: begin
					// Request goes out with the AR handshake
					if (ar_hs) begin
						rd_state <= RD_WAIT;
					end
				end
				RD_WAIT: begin
					if (i_tx_dval) begin
						rd_state <= RD_RESP;
					end
				end
				RD_RESP: begin
					if (i_s_axi_rready) begin
						rd_state <= RD_IDLE;
					end
				end
				default: begin
					rd_state <= RD_IDLE;
				end
			endcase
		end
	end

	// Read address latch
	always_ff @(posedge S_AXI_ACLK) begin
		if (ar_accept) begin
			rd_addr <= i_s_axi_araddr;
		end
	end

	// Returned data held stable until RREADY
	always_ff @(posedge S_AXI_ACLK) begin
		if ((rd_state == RD_WAIT) && i_tx_dval) begin
			rd_data <= i_tx_data;
		end
	end

	// AXI outputs
	assign o_s_axi_awready = axi_awready;
	assign o_s_axi_wready  = axi_wready;
	assign o_s_axi_bresp   = `AXI_RESP_OKAY;
	assign o_s_axi_bvalid  = axi_bvalid;
	assign o_s_axi_arready = axi_arready;
	assign o_s_axi_rdata   = rd_data;
	assign o_s_axi_rresp   = `AXI_RESP_OKAY;
	assign o_s_axi_rvalid  = (rd_state == RD_RESP);

	// Local bus outputs
	assign o_rx_dval = wr_hs;
	assign o_rx_addr = wr_addr;
	assign o_rx_data = wr_data;
	assign o_tx_req  = ar_hs;
	assign o_tx_addr = rd_addr;

endmodule

`default_nettype wire

// File: hw/axi_tmr_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "tmr_macros.svh"

module axi_tmr_top
	import tmr_pkg::*;
(
	input  wire                      S_AXI_ACLK,
	input  wire                      S_AXI_ARESETN,
	input  wire [`AXI_ADDR_W-1:0]    i_s_axi_awaddr,
	input  wire                      i_s_axi_awvalid,
	input  wire [2:0]                i_s_axi_awprot,
	output wire                      o_s_axi_awready,
	input  wire [`AXI_DATA_W-1:0]    i_s_axi_wdata,
	input  wire [`AXI_DATA_W/8-1:0]  i_s_axi_wstrb,
	input  wire                      i_s_axi_wvalid,
	output wire                      o_s_axi_wready,
	output wire [1:0]                o_s_axi_bresp,
	output wire                      o_s_axi_bvalid,
	input  wire                      i_s_axi_bready,
	input  wire [`AXI_ADDR_W-1:0]    i_s_axi_araddr,
	input  wire                      i_s_axi_arvalid,
	input  wire [2:0]                i_s_axi_arprot,
	output wire                      o_s_axi_arready,
	output wire [`AXI_DATA_W-1:0]    o_s_axi_rdata,
	output wire [1:0]                o_s_axi_rresp,
	output wire                      o_s_axi_rvalid,
	input  wire                      i_s_axi_rready,
	output wire                      o_irq
);

	// Local bus
	wire                   rx_dval;
	wire [`AXI_ADDR_W-1:0] rx_addr;
	wire [`AXI_DATA_W-1:0] rx_data;
	wire                   tx_req;
	wire [`AXI_ADDR_W-1:0] tx_addr;
	wire [`AXI_DATA_W-1:0] tx_data;
	wire                   tx_dval;

	// Timer path
	wire                   tmr_enable;
	tmr_mode_t             tmr_mode;
	wire [`AXI_DATA_W-1:0] load_value;
	wire                   cnt_load;
	wire                   cnt_dec;
	wire [`AXI_DATA_W-1:0] cnt_value;
	wire                   cnt_zero;
	wire                   tmr_expire;
	wire                   tmr_running;

	axi_lite_slave i_axi_lite_slave (
		.S_AXI_ACLK      (S_AXI_ACLK),
		.S_AXI_ARESETN   (S_AXI_ARESETN),
		.i_s_axi_awaddr  (i_s_axi_awaddr),
		.i_s_axi_awvalid (i_s_axi_awvalid),
		.i_s_axi_awprot  (i_s_axi_awprot),
		.o_s_axi_awready (o_s_axi_awready),
		.i_s_axi_wdata   (i_s_axi_wdata),
		.i_s_axi_wstrb   (i_s_axi_wstrb),
		.i_s_axi_wvalid  (i_s_axi_wvalid),
		.o_s_axi_wready  (o_s_axi_wready),
		.o_s_axi_bresp   (o_s_axi_bresp),
		.o_s_axi_bvalid  (o_s_axi_bvalid),
		.i_s_axi_bready  (i_s_axi_bready),
		.i_s_axi_araddr  (i_s_axi_araddr),
		.i_s_axi_arvalid (i_s_axi_arvalid),
		.i_s_axi_arprot  (i_s_axi_arprot),
		.o_s_axi_arready (o_s_axi_arready),
		.o_s_axi_rdata   (o_s_axi_rdata),
		.o_s_axi_rresp   (o_s_axi_rresp),
		.o_s_axi_rvalid  (o_s_axi_rvalid),
		.i_s_axi_rready  (i_s_axi_rready),
		.o_rx_dval       (rx_dval),
		.o_rx_addr       (rx_addr),
		.o_rx_data       (rx_data),
		.o_tx_req        (tx_req),
		.o_tx_addr       (tx_addr),
		.i_tx_data       (tx_data),
		.i_tx_dval       (tx_dval)
	);

	lb_regs i_lb_regs (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_rx_dval     (rx_dval),
		.i_rx_addr     (rx_addr),
		.i_rx_data     (rx_data),
		.i_tx_req      (tx_req),
		.i_tx_addr     (tx_addr),
		.o_tx_data     (tx_data),
		.o_tx_dval     (tx_dval),
		.i_count       (cnt_value),
		.i_expire      (tmr_expire),
		.i_running     (tmr_running),
		.o_enable      (tmr_enable),
		.o_mode        (tmr_mode),
		.o_load_value  (load_value),
		.o_irq         (o_irq)
	);

	tmr_ctrl i_tmr_ctrl (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_enable      (tmr_enable),
		.i_mode        (tmr_mode),
		.i_zero        (cnt_zero),
		.o_load        (cnt_load),
		.o_dec         (cnt_dec),
		.o_expire      (tmr_expire),
		.o_running     (tmr_running)
	);

	tmr_counter i_tmr_counter (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_load        (cnt_load),
		.i_load_value  (load_value),
		.i_dec         (cnt_dec),
		.o_count       (cnt_value),
		.o_zero        (cnt_zero)
	);

endmodule

`default_nettype wire

// File: hw/lb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "tmr_macros.svh"

module lb_regs
	import tmr_pkg::*;
(
	input  wire                   S_AXI_ACLK,
	input  wire                   S_AXI_ARESETN,
	// Local write bus
	input  wire                   i_rx_dval,
	input  wire [`AXI_ADDR_W-1:0] i_rx_addr,
	input  wire [`AXI_DATA_W-1:0] i_rx_data,
	// Local read bus
	input  wire                   i_tx_req,
	input  wire [`AXI_ADDR_W-1:0] i_tx_addr,
	output logic [`AXI_DATA_W-1:0] o_tx_data,
	output logic                  o_tx_dval,
	// Timer side
	input  wire [`AXI_DATA_W-1:0] i_count,
	input  wire                   i_expire,
	input  wire                   i_running,
	output wire                   o_enable,
	output tmr_mode_t             o_mode,
	output wire [`AXI_DATA_W-1:0] o_load_value,
	output wire                   o_irq
);

	logic [`REG_ADDR_MSB:0] wr_off;
	logic [`REG_ADDR_MSB:0] rd_off;
	logic                   ctrl_en;
	tmr_mode_t              ctrl_mode;
	logic                   ctrl_ie;
	logic [`AXI_DATA_W-1:0] load_value;
	logic                   stat_exp;
	logic                   stat_clr;
	logic [`AXI_DATA_W-1:0] scratch0;
	logic [`AXI_DATA_W-1:0] scratch1;
	logic [`AXI_DATA_W-1:0] rd_mux;

	// Word aligned offsets, upper bits ignored
	assign wr_off = {i_rx_addr[`REG_ADDR_MSB:`REG_ADDR_LSB], {`REG_ADDR_LSB{1'b0}}};
	assign rd_off = {i_tx_addr[`REG_ADDR_MSB:`REG_ADDR_LSB], {`REG_ADDR_LSB{1'b0}}};

	//////////////////////////////
	// Write decode
	//////////////////////////////

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			ctrl_en    <= 1'b0;
			ctrl_mode  <= TMR_ONESHOT;
			ctrl_ie    <= 1'b0;
			load_value <= '0;
			scratch0   <= '0;
			scratch1   <= '0;
		end else if (i_rx_dval) begin
			case (wr_off)
				`REG_CTRL: begin
					ctrl_en   <= i_rx_data[`CTRL_EN_BIT];
					ctrl_mode <= tmr_mode_t'(i_rx_data[`CTRL_MODE_BIT]);
					ctrl_ie   <= i_rx_data[`CTRL_IE_BIT];
				end
				`REG_LOAD:     load_value <= i_rx_data;
				`REG_SCRATCH0: scratch0 <= i_rx_data;
				`REG_SCRATCH1: scratch1 <= i_rx_data;
				// COUNT is read only, STATUS handled below
				default: ;
			endcase
		end
	end

	// Write one to clear the expired flag
	assign stat_clr = i_rx_dval && (wr_off == `REG_STATUS) && i_rx_data[`STAT_EXP_BIT];

	// Sticky expired bit, a new expiry beats a clear
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			stat_exp <= 1'b0;
		end else if (i_expire) begin
			stat_exp <= 1'b1;
		end else if (stat_clr) begin
			stat_exp <= 1'b0;
		end
	end

	//////////////////////////////
	// Read return
	//////////////////////////////

	always_comb begin
		rd_mux = '0;
		case (rd_off)
			`REG_CTRL: begin
				rd_mux[`CTRL_EN_BIT]   = ctrl_en;
				rd_mux[`CTRL_MODE_BIT] = ctrl_mode;
				rd_mux[`CTRL_IE_BIT]   = ctrl_ie;
			end
			`REG_LOAD:  rd_mux = load_value;
			`REG_COUNT: rd_mux = i_count;
			`REG_STATUS: begin
				rd_mux[`STAT_EXP_BIT] = stat_exp;
				rd_mux[`STAT_RUN_BIT] = i_running;
			end
			`REG_SCRATCH0: rd_mux = scratch0;
			`REG_SCRATCH1: rd_mux = scratch1;
			// Unmapped offsets read as zero
			default: rd_mux = '0;
		endcase
	end

	// Valid strobe one cycle after the request
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			o_tx_dval <= 1'b0;
		end else begin
			o_tx_dval <= i_tx_req;
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (i_tx_req) begin
			o_tx_data <= rd_mux;
		end
	end

	// Timer controls
	assign o_enable     = ctrl_en;
	assign o_mode       = ctrl_mode;
	assign o_load_value = load_value;

	// Interrupt from expired flag when enabled
	assign o_irq = stat_exp & ctrl_ie;

endmodule

`default_nettype wire

// File: hw/tmr_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "tmr_macros.svh"

module tmr_counter (
	input  wire                   S_AXI_ACLK,
	input  wire                   S_AXI_ARESETN,
	input  wire                   i_load,
	input  wire [`AXI_DATA_W-1:0] i_load_value,
	input  wire                   i_dec,
	output wire [`AXI_DATA_W-1:0] o_count,
	output wire                   o_zero
);

	logic [`AXI_DATA_W-1:0] count;
	logic                   at_zero;

	assign at_zero = (count == '0);

	// Load beats decrement
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			count <= '0;
		end else if (i_load) begin
			count <= i_load_value;
		end else if (i_dec && !at_zero) begin
			// Saturates at zero
			count <= count - 1'b1;
		end
	end

	assign o_count = count;
	assign o_zero  = at_zero;

endmodule

`default_nettype wire

// File: hw/tmr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tmr_ctrl
	import tmr_pkg::*;
(
	input  wire       S_AXI_ACLK,
	input  wire       S_AXI_ARESETN,
	input  wire       i_enable,
	input  tmr_mode_t i_mode,
	input  wire       i_zero,
	output logic      o_load,
	output wire       o_dec,
	output wire       o_expire,
	output wire       o_running
);

	tmr_state_t state;
	logic       expire;

	// Zero seen while running, ignored in the load cycle
	assign expire = (state == TMR_RUN) && i_enable && !o_load && i_zero;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			state  <= TMR_IDLE;
			o_load <= 1'b0;
		end else begin
			o_load <= 1'b0;
			if (!i_enable) begin
				// Disable returns to idle from anywhere
				state <= TMR_IDLE;
			end else begin
				case (state)
					TMR_IDLE: begin
						state  <= TMR_RUN;
						o_load <= 1'b1;
					end
					TMR_RUN: begin
						if (expire) begin
							if (i_mode == TMR_PERIODIC) begin
								// Reload and keep running
								o_load <= 1'b1;
							end else begin
								state <= TMR_DONE;
							end
						end
					end
					// Parked until enable drops
					TMR_DONE: state <= TMR_DONE;
					default:  state <= TMR_IDLE;
				endcase
			end
		end
	end

	// Count down only between load and zero
	assign o_dec     = (state == TMR_RUN) && !o_load && !i_zero;
	assign o_expire  = expire;
	assign o_running = (state == TMR_RUN);

endmodule

`default_nettype wire

// File: hw/tmr_macros.svh
`ifndef TMR_MACROS_SVH
`define TMR_MACROS_SVH

// Bus widths
`define AXI_DATA_W 32
`define AXI_ADDR_W 32

// AXI response code
`define AXI_RESP_OKAY 2'b00

// Word offset bits and top decoded address bit
`define REG_ADDR_LSB 2
`define REG_ADDR_MSB 4

// Register byte offsets, compared against address bits 4..0
`define REG_CTRL     5'h00
`define REG_LOAD     5'h04
`define REG_COUNT    5'h08
`define REG_STATUS   5'h0C
`define REG_SCRATCH0 5'h10
`define REG_SCRATCH1 5'h14

// CTRL fields
`define CTRL_EN_BIT   0
`define CTRL_MODE_BIT 1
`define CTRL_IE_BIT   2

// STATUS fields
`define STAT_EXP_BIT 0
`define STAT_RUN_BIT 1

`endif

// File: hw/tmr_pkg.sv
`default_nettype none

package tmr_pkg;

	// Timer opcode held in CTRL bit 1
	typedef enum logic {
		TMR_ONESHOT  = 1'b0,
		TMR_PERIODIC = 1'b1
	} tmr_mode_t;

	// Timer sequencing states
	typedef enum logic [1:0] {
		TMR_IDLE = 2'd0,
		TMR_RUN  = 2'd1,
		TMR_DONE = 2'd2
	} tmr_state_t;

	// Bridge read channel states
	typedef enum logic [1:0] {
		RD_IDLE = 2'd0,
		RD_WAIT = 2'd1,
		RD_RESP = 2'd2
	} rd_state_t;

endpackage

`default_nettype wire
